/* hdl/clint_pkg.sv */
`default_nettype none

package clint_pkg;

    // harts served by this block
    localparam int num_harts = 2;

    // bus geometry
    localparam int addr_w = 64;
    localparam int off_w  = 16;
    localparam int data_w = 64;
    localparam int strb_w = data_w / 8;

    typedef logic [data_w-1:0] axi_data_t;
    typedef logic [strb_w-1:0] axi_strb_t;
    typedef logic [off_w-1:0]  reg_off_t;
    typedef logic [63:0]       time_t;

    // register map, offsets inside the CLINT window
    // msip of hart h sits in byte lane 4h of the first doubleword
    localparam reg_off_t msip_base     = 16'h0000;
    // one doubleword per hart
    localparam reg_off_t mtimecmp_base = 16'h4000;
    localparam reg_off_t mtime_off     = 16'hBFF8;

    localparam logic [1:0] resp_okay = 2'b00;

    // single register access handed from the bus side to the register file
    typedef struct packed {
        logic      valid;
        logic      write;
        reg_off_t  off;
        axi_data_t wdata;
        axi_strb_t wstrb;
    } reg_req_t;

    // one transaction in flight at a time
    typedef enum logic [2:0] {
        IDLE,
        WR_COLLECT,
        WR_APPLY,
        WR_RESP,
        RD_APPLY,
        RD_RESP
    } slave_state_e;

endpackage

`default_nettype wire

/* hdl/clint_axi_slave.sv */
`default_nettype none

module clint_axi_slave (
    input  wire                            clk,
    input  wire                            rst_n,

    // read address channel
    input  wire  [clint_pkg::addr_w-1:0]   araddr,
    input  wire  [2:0]                     arprot,
    input  wire                            arvalid,
    output logic                           arready,

    // read data channel
    output clint_pkg::axi_data_t           rdata_out,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  wire                            rready,

    // write address channel
    input  wire  [clint_pkg::addr_w-1:0]   awaddr,
    input  wire  [2:0]                     awprot,
    input  wire                            awvalid,
    output logic                           awready,

    // write data channel
    input  wire  clint_pkg::axi_data_t     wdata,
    input  wire  clint_pkg::axi_strb_t     wstrb,
    input  wire                            wvalid,
    output logic                           wready,

    // write response channel
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  wire                            bready,

    // register file side
    input  wire  clint_pkg::axi_data_t     rdata,
    output clint_pkg::reg_req_t            req
);
    import clint_pkg::*;

    slave_state_e state;
    slave_state_e state_nxt;

    // which half of a write has already been taken
    logic aw_got;
    logic w_got;

    logic wr_phase;
    logic aw_hs;
    logic w_hs;
    logic ar_hs;
    logic aw_done;
    logic w_done;

    // latched transaction payload
    reg_off_t  off_q;
    axi_data_t wdata_q;
    axi_strb_t wstrb_q;
    axi_data_t rdata_q;

    // AW and W may arrive in any order while no response is pending
    assign wr_phase = (state == IDLE) || (state == WR_COLLECT);
    assign awready  = wr_phase && !aw_got && awvalid;
    assign wready   = wr_phase && !w_got && wvalid;

    // a write that shows up together with a read goes first
    assign arready  = (state == IDLE) && arvalid && !awvalid && !wvalid;

    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;
    assign ar_hs   = arvalid && arready;
    assign aw_done = aw_got || aw_hs;
    assign w_done  = w_got || w_hs;

    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:
            begin
                if (aw_hs || w_hs)
                begin
                    state_nxt = (aw_done && w_done) ? WR_APPLY : WR_COLLECT;
                end
                else if (ar_hs)
                begin
                    state_nxt = RD_APPLY;
                end
            end
            WR_COLLECT:
            begin
                if (aw_done && w_done)
                begin
                    state_nxt = WR_APPLY;
                end
            end
            WR_APPLY:   state_nxt = WR_RESP;
            WR_RESP:
            begin
                if (bready)
                begin
                    state_nxt = IDLE;
                end
            end
            RD_APPLY:   state_nxt = RD_RESP;
            RD_RESP:
            begin
                if (rready)
                begin
                    state_nxt = IDLE;
                end
            end
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state  <= IDLE;
            aw_got <= 1'b0;
            w_got  <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (state == WR_APPLY)
            begin
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end
            else
            begin
                if (aw_hs)
                begin
                    aw_got <= 1'b1;
                end
                if (w_hs)
                begin
                    w_got <= 1'b1;
                end
            end
        end
    end

    // only the low offset bits select a register, prot is ignored
    always_ff @(posedge clk)
    begin
        if (aw_hs)
        begin
            off_q <= awaddr[off_w-1:0];
        end
        else if (ar_hs)
        begin
            off_q <= araddr[off_w-1:0];
        end
        if (w_hs)
        begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        // read data from the register file is valid while the read request is out
        if (state == RD_APPLY)
        begin
            rdata_q <= rdata;
        end
    end

    always_comb
    begin
        req.valid = (state == WR_APPLY) || (state == RD_APPLY);
        req.write = (state == WR_APPLY);
        req.off   = off_q;
        req.wdata = wdata_q;
        req.wstrb = wstrb_q;
    end

    assign rvalid    = (state == RD_RESP);
    assign rdata_out = rdata_q;
    assign rresp     = resp_okay;
    assign bvalid    = (state == WR_RESP);
    assign bresp     = resp_okay;

    // each transaction reaches the register file exactly once
    req_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        req.valid |=> !req.valid);

    // only one response channel is ever busy
    resp_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(rvalid && bvalid));

endmodule

`default_nettype wire

/* hdl/clint_regs.sv */
`default_nettype none

module clint_regs (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire  clint_pkg::reg_req_t         req,
    output clint_pkg::axi_data_t              rdata,
    output clint_pkg::time_t                  mtime,
    output clint_pkg::time_t                  mtimecmp [clint_pkg::num_harts],
    output logic [clint_pkg::num_harts-1:0]   msip
);
    import clint_pkg::*;

    logic                 hit_msip;
    logic                 hit_mtime;
    logic [num_harts-1:0] hit_cmp;
    logic                 wr_en;

    // replace only the bytes whose strobe is set
    function automatic time_t merge_bytes(
        input time_t     cur,
        input axi_data_t data,
        input axi_strb_t strb
    );
        time_t res;
        res = cur;
        for (int b = 0; b < strb_w; b++)
        begin
            if (strb[b])
            begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // address decode
    always_comb
    begin
        hit_msip  = (req.off == msip_base);
        hit_mtime = (req.off == mtime_off);
        for (int h = 0; h < num_harts; h++)
        begin
            hit_cmp[h] = (req.off == mtimecmp_base + reg_off_t'(8 * h));
        end
    end

    assign wr_en = req.valid && req.write;

    // free-running counter, a software write takes priority over the increment
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtime <= '0;
        end
        else if (wr_en && hit_mtime)
        begin
            mtime <= merge_bytes(mtime, req.wdata, req.wstrb);
        end
        else
        begin
            mtime <= mtime + 1'b1;
        end
    end

    // all ones keeps the timer interrupt quiet until software arms it
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int h = 0; h < num_harts; h++)
            begin
                mtimecmp[h] <= '1;
            end
        end
        else
        begin
            for (int h = 0; h < num_harts; h++)
            begin
                if (wr_en && hit_cmp[h])
                begin
                    mtimecmp[h] <= merge_bytes(mtimecmp[h], req.wdata, req.wstrb);
                end
            end
        end
    end

    // msip of hart h is bit 0 of byte lane 4h
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            msip <= '0;
        end
        else if (wr_en && hit_msip)
        begin
            for (int h = 0; h < num_harts; h++)
            begin
                if (req.wstrb[4*h])
                begin
                    msip[h] <= req.wdata[32*h];
                end
            end
        end
    end

    // read mux, unmapped offsets read as zero
    always_comb
    begin
        rdata = '0;
        if (hit_msip)
        begin
            for (int h = 0; h < num_harts; h++)
            begin
                rdata[32*h] = msip[h];
            end
        end
        if (hit_mtime)
        begin
            rdata = mtime;
        end
        for (int h = 0; h < num_harts; h++)
        begin
            if (hit_cmp[h])
            begin
                rdata = mtimecmp[h];
            end
        end
    end

    // the map must not overlap, whatever num_harts is
    decode_unique: assert property (@(posedge clk) disable iff (!rst_n)
        req.valid |-> $onehot0({hit_msip, hit_mtime, hit_cmp}));

endmodule

`default_nettype wire

/* hdl/clint_irq.sv */
`default_nettype none

module clint_irq (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire  clint_pkg::time_t            mtime,
    input  wire  clint_pkg::time_t            mtimecmp [clint_pkg::num_harts],
    output logic [clint_pkg::num_harts-1:0]   mtip
);
    import clint_pkg::*;

    logic [num_harts-1:0] due;

    // unsigned compare per hart
    always_comb
    begin
        for (int h = 0; h < num_harts; h++)
        begin
            due[h] = (mtime >= mtimecmp[h]);
        end
    end

    // registered so the level seen by the hart never glitches
    // it drops again once software moves mtimecmp past mtime
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtip <= '0;
        end
        else
        begin
            mtip <= due;
        end
    end

endmodule

`default_nettype wire

/* hdl/clint_top.sv */
`default_nettype none

module clint_top (
    input  wire                               clk,
    input  wire                               rst_n,

    input  wire  [clint_pkg::addr_w-1:0]      araddr,
    input  wire  [2:0]                        arprot,
    input  wire                               arvalid,
    output logic                              arready,

    output clint_pkg::axi_data_t              rdata,
    output logic [1:0]                        rresp,
    output logic                              rvalid,
    input  wire                               rready,

    input  wire  [clint_pkg::addr_w-1:0]      awaddr,
    input  wire  [2:0]                        awprot,
    input  wire                               awvalid,
    output logic                              awready,

    input  wire  clint_pkg::axi_data_t        wdata,
    input  wire  clint_pkg::axi_strb_t        wstrb,
    input  wire                               wvalid,
    output logic                              wready,

    output logic [1:0]                        bresp,
    output logic                              bvalid,
    input  wire                               bready,

    // interrupt levels, one per hart
    output logic [clint_pkg::num_harts-1:0]   mtip,
    output logic [clint_pkg::num_harts-1:0]   msip
);
    import clint_pkg::*;

    reg_req_t  reg_req;
    axi_data_t reg_rdata;
    time_t     mtime;
    time_t     mtimecmp [num_harts];

    clint_axi_slave slave_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .araddr    (araddr),
        .arprot    (arprot),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata_out (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .awaddr    (awaddr),
        .awprot    (awprot),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .rdata     (reg_rdata),
        .req       (reg_req)
    );

    clint_regs regs_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (reg_req),
        .rdata    (reg_rdata),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .msip     (msip)
    );

    clint_irq irq_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .mtip     (mtip)
    );

endmodule

`default_nettype wire

/* testbench/clint_tb.sv */
`default_nettype none

module clint_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import clint_pkg::*;

    logic                 clk;
    logic                 rst_n;
    logic [addr_w-1:0]    araddr;
    logic [2:0]           arprot;
    logic                 arvalid;
    logic                 arready;
    axi_data_t            rdata;
    logic [1:0]           rresp;
    logic                 rvalid;
    logic                 rready;
    logic [addr_w-1:0]    awaddr;
    logic [2:0]           awprot;
    logic                 awvalid;
    logic                 awready;
    axi_data_t            wdata;
    axi_strb_t            wstrb;
    logic                 wvalid;
    logic                 wready;
    logic [1:0]           bresp;
    logic                 bvalid;
    logic                 bready;
    logic [num_harts-1:0] mtip;
    logic [num_harts-1:0] msip;

    int          errors;
    int          checks;
    int          tests;
    logic [63:0] rng_state;

    clint_top dut_i (
        .clk(clk), .rst_n(rst_n),
        .araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awprot(awprot), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .mtip(mtip), .msip(msip)
    );

    always #10 clk = ~clk;

    function automatic logic [63:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    function automatic logic [63:0] cmp_addr(input int h);
        return 64'(mtimecmp_base) + 64'(8 * h);
    endfunction

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // hold > 0 keeps bready low that many cycles with a competing AR request pending
    task automatic axi_write(input logic [63:0] addr, input axi_data_t data,
                             input axi_strb_t strb, input int hold);
        logic aw_pend;
        logic w_pend;
        logic fire_aw;
        logic fire_w;
        int   n;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        bready  <= (hold == 0);
        aw_pend = 1'b1;
        w_pend  = 1'b1;
        n = 0;
        while ((aw_pend || w_pend) && n < 50)
        begin
            @(negedge clk);
            fire_aw = aw_pend && awready;
            fire_w  = w_pend && wready;
            @(posedge clk);
            if (fire_aw)
            begin
                awvalid <= 1'b0;
                aw_pend = 1'b0;
            end
            if (fire_w)
            begin
                wvalid <= 1'b0;
                w_pend = 1'b0;
            end
            n++;
        end
        if (aw_pend || w_pend)
        begin
            $display("write to %h was never accepted by the slave", addr);
            errors++;
            return;
        end
        if (hold > 0)
        begin
            araddr  <= addr;
            arvalid <= 1'b1;
        end
        n = 0;
        @(negedge clk);
        while (!bvalid && n < 50)
        begin
            @(negedge clk);
            n++;
        end
        if (!bvalid)
        begin
            $display("write to %h got no write response", addr);
            errors++;
            return;
        end
        if (hold > 0)
        begin
            for (int i = 0; i < hold; i++)
            begin
                check("bvalid held under back-pressure", 64'(bvalid), 64'd1);
                check("arready while B pending", 64'(arready), 64'd0);
                @(negedge clk);
            end
            @(posedge clk);
            bready  <= 1'b1;
            arvalid <= 1'b0;
            @(negedge clk);
            check("bvalid before handshake", 64'(bvalid), 64'd1);
        end
        check("bresp", 64'(bresp), 64'(resp_okay));
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [63:0] addr, input int hold, output axi_data_t data);
        logic fired;
        int   n;
        data = '0;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= (hold == 0);
        fired = 1'b0;
        n = 0;
        while (!fired && n < 50)
        begin
            @(negedge clk);
            fired = arready;
            @(posedge clk);
            n++;
        end
        if (!fired)
        begin
            $display("read of %h was never accepted by the slave", addr);
            errors++;
            arvalid <= 1'b0;
            return;
        end
        // with back-pressure the request stays up as a second read that must wait
        if (hold == 0)
        begin
            arvalid <= 1'b0;
        end
        n = 0;
        @(negedge clk);
        while (!rvalid && n < 50)
        begin
            @(negedge clk);
            n++;
        end
        if (!rvalid)
        begin
            $display("read of %h returned no data", addr);
            errors++;
            return;
        end
        data = rdata;
        check("rresp", 64'(rresp), 64'(resp_okay));
        if (hold > 0)
        begin
            for (int i = 0; i < hold; i++)
            begin
                check("rvalid held under back-pressure", 64'(rvalid), 64'd1);
                check("rdata stable under back-pressure", rdata, data);
                check("arready while R pending", 64'(arready), 64'd0);
                @(negedge clk);
            end
            @(posedge clk);
            rready  <= 1'b1;
            arvalid <= 1'b0;
            @(negedge clk);
            check("rvalid before handshake", 64'(rvalid), 64'd1);
        end
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        $display("test %s: %0d errors", name, errors - err_before);
    endtask

    task automatic reset_values();
        int        e0;
        axi_data_t d;
        e0 = errors;
        @(negedge clk);
        check("mtip after reset", 64'(mtip), 64'd0);
        check("msip after reset", 64'(msip), 64'd0);
        for (int h = 0; h < num_harts; h++)
        begin
            axi_read(cmp_addr(h), 0, d);
            check("mtimecmp reset value", d, '1);
        end
        finish_test("reset", e0);
    endtask

    task automatic cmp_roundtrip();
        int          e0;
        axi_data_t   a;
        axi_data_t   b;
        axi_data_t   d;
        logic [63:0] mask;
        axi_strb_t   strb;
        e0 = errors;
        for (int h = 0; h < num_harts; h++)
        begin
            a = xorshift();
            axi_write(cmp_addr(h), a, '1, 0);
            axi_read(cmp_addr(h), 0, d);
            check("mtimecmp full write", d, a);
        end
        b = xorshift();
        strb = 8'h5A;
        for (int i = 0; i < strb_w; i++)
        begin
            mask[8*i +: 8] = {8{strb[i]}};
        end
        axi_write(cmp_addr(1), b, strb, 0);
        axi_read(cmp_addr(1), 0, d);
        check("mtimecmp partial write", d, (a & ~mask) | (b & mask));
        // park both comparators so later tests start quiet
        for (int h = 0; h < num_harts; h++)
        begin
            axi_write(cmp_addr(h), '1, '1, 0);
        end
        finish_test("mtimecmp round trip", e0);
    endtask

    task automatic mtime_count();
        int          e0;
        logic [63:0] v;
        axi_data_t   first;
        axi_data_t   second;
        e0 = errors;
        v = xorshift() & 64'h00FF_FFFF_FFFF_FFFF;
        axi_write(64'(mtime_off), v, '1, 0);
        axi_read(64'(mtime_off), 0, first);
        axi_read(64'(mtime_off), 0, second);
        check("first mtime read in window", 64'((first >= v) && (first < v + 20)), 64'd1);
        check("mtime advances", 64'(second > first), 64'd1);
        finish_test("mtime", e0);
    endtask

    task automatic timer_irq();
        int        e0;
        int        n;
        axi_data_t t;
        e0 = errors;
        axi_read(64'(mtime_off), 0, t);
        axi_write(cmp_addr(0), t + 40, '1, 0);
        n = 0;
        @(negedge clk);
        while (!mtip[0] && n < 100)
        begin
            check("mtip[1] stays low", 64'(mtip[1]), 64'd0);
            @(negedge clk);
            n++;
        end
        if (!mtip[0])
        begin
            $display("mtip[0] did not rise after mtimecmp was reached");
            errors++;
        end
        axi_write(cmp_addr(0), '1, '1, 0);
        n = 0;
        @(negedge clk);
        while (mtip[0] && n < 10)
        begin
            @(negedge clk);
            n++;
        end
        if (mtip[0])
        begin
            $display("mtip[0] did not clear after mtimecmp was raised");
            errors++;
        end
        finish_test("timer interrupt", e0);
    endtask

    task automatic soft_irq();
        int        e0;
        axi_data_t d;
        e0 = errors;
        // bit 0 is set too, its lane strobe is off so hart 0 must stay quiet
        axi_write(64'(msip_base), 64'h1_0000_0001, 8'h10, 0);
        @(negedge clk);
        check("msip after lane 4 set", 64'(msip), 64'b10);
        axi_read(64'(msip_base), 0, d);
        check("msip readback", d, 64'h1_0000_0000);
        axi_write(64'(msip_base), 64'h0, 8'h10, 0);
        @(negedge clk);
        check("msip after lane 4 clear", 64'(msip), 64'b00);
        finish_test("software interrupt", e0);
    endtask

    task automatic unmapped_backpressure();
        int        e0;
        axi_data_t d;
        e0 = errors;
        axi_write(64'h1000, xorshift(), '1, 0);
        axi_read(64'h1000, 0, d);
        check("unmapped read", d, 64'h0);
        axi_read(64'(mtime_off), 5, d);
        axi_write(cmp_addr(1), '1, '1, 5);
        finish_test("unmapped and back-pressure", e0);
    endtask

    initial
    begin
        clk = 1'b0;
        rst_n = 1'b0;
        araddr = '0;
        arprot = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        awaddr = '0;
        awprot = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        rng_state = 64'd52;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        reset_values();
        cmp_roundtrip();
        mtime_count();
        timer_irq();
        soft_irq();
        unmapped_backpressure();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
hdl/clint_pkg.sv
hdl/clint_axi_slave.sv
hdl/clint_regs.sv
hdl/clint_irq.sv
hdl/clint_top.sv
testbench/clint_tb.sv

/* Bender.yml */
package:
  name: clint

sources:
  - hdl/clint_pkg.sv
  - hdl/clint_axi_slave.sv
  - hdl/clint_regs.sv
  - hdl/clint_irq.sv
  - hdl/clint_top.sv
  - target: test
    files:
      - testbench/clint_tb.sv
